//--- Makefile
TOP = mpu_tb

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

//--- access_check.sv
`timescale 1ns/1ps

module access_check (
    input  logic                                clk_i,
    input  logic                                reset_i,
    // captured request, valid for one cycle
    input  mpu_bus_pkg::req_t                   req_i,
    // register window write
    input  mpu_map_pkg::map_wr_t                wr_i,
    input  logic                                mapen_i,
    // current operating level
    input  logic [mpu_map_pkg::OL_W-1:0]        ol_i,
    output mpu_map_pkg::viol_t                  viol_o,
    // permission half of a window readback
    output mpu_map_pkg::perm_t                  rd_perm_o
);

    // rights of each virtual page
    mpu_map_pkg::perm_t perm_mem [mpu_map_pkg::N_ENT];

    mpu_map_pkg::perm_t            ent;
    logic [mpu_map_pkg::IDX_W-1:0] va_idx;
    logic [mpu_map_pkg::IDX_W-1:0] rd_idx;
    logic                          mapped;
    logic                          beyond;
    logic                          denied;

    assign va_idx = req_i.adr[mpu_map_pkg::PAGE_BITS +: mpu_map_pkg::IDX_W];
    assign rd_idx = req_i.adr[mpu_map_pkg::WIN_IDX_LSB +: mpu_map_pkg::IDX_W];
    assign ent = perm_mem[va_idx];

    // only ordinary accesses go through the map
    assign mapped = mapen_i && !req_i.win;

    // anything at or above 256 KB has no entry
    assign beyond = |req_i.adr[mpu_bus_pkg::ADR_W-1:mpu_map_pkg::VA_BITS];

    // common part of every kind of violation
    assign denied = !ent.valid || (ol_i > ent.pl) || beyond;

    // ==========================================================
    // table write port
    // ==========================================================

    // reset leaves every page unmapped
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < mpu_map_pkg::N_ENT; i++) begin
                perm_mem[i].valid <= 1'b0;
            end
        end else if (wr_i.en) begin
            perm_mem[wr_i.idx] <= wr_i.dat[mpu_map_pkg::PERM_LSB +: $bits(mpu_map_pkg::perm_t)];
        end
    end

    // ==========================================================
    // registered violation decision
    // ==========================================================

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            viol_o    <= '0;
            rd_perm_o <= '0;
        end else if (req_i.valid) begin
            // a fetch is checked against x only
            viol_o.exv <= mapped && req_i.ex && (denied || !ent.x);
            viol_o.rdv <= mapped && !req_i.ex && !req_i.we && (denied || !ent.r);
            // window writes need level 0 whatever the mapping state
            viol_o.wrv <= (mapped && !req_i.ex && req_i.we && (denied || !ent.w))
                       || (req_i.win && req_i.we && (ol_i != '0));
            if (req_i.win && !req_i.we) begin
                rd_perm_o <= perm_mem[rd_idx];
            end
        end
    end

endmodule

//--- bus_gate.sv
`timescale 1ns/1ps

module bus_gate (
    input  logic                                clk_i,
    input  logic                                reset_i,
    // slave port from the master
    input  logic                                cyc_i,
    input  logic                                stb_i,
    input  logic                                we_i,
    input  logic                                ex_i,
    input  logic [mpu_bus_pkg::ADR_W-1:0]       adr_i,
    input  logic [mpu_bus_pkg::DAT_W-1:0]       dat_i,
    output logic                                ack_o,
    output logic                                err_o,
    output logic [mpu_bus_pkg::DAT_W-1:0]       dat_o,
    // outbound memory bus
    output logic                                m_cyc_o,
    output logic                                m_stb_o,
    output logic                                m_we_o,
    output logic [mpu_bus_pkg::ADR_W-1:0]       m_adr_o,
    output logic [mpu_bus_pkg::DAT_W-1:0]       m_dat_o,
    input  logic                                m_ack_i,
    input  logic [mpu_bus_pkg::DAT_W-1:0]       m_dat_i,
    // to and from the two lookups
    output mpu_bus_pkg::req_t                   req_o,
    output mpu_map_pkg::map_wr_t                wr_o,
    input  logic [mpu_map_pkg::PPN_W-1:0]       ppn_i,
    input  mpu_map_pkg::viol_t                  viol_i,
    input  logic [mpu_map_pkg::PPN_W-1:0]       rd_ppn_i,
    input  mpu_map_pkg::perm_t                  rd_perm_i,
    // fault flags, one cycle with the error ack
    output logic                                exv_o,
    output logic                                rdv_o,
    output logic                                wrv_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOK,
        ST_OUT,
        ST_RESP
    } state_t;

    state_t                          state_q;
    mpu_bus_pkg::req_t               req_q;
    mpu_bus_pkg::rsp_t               rsp_q;
    mpu_bus_pkg::out_t               out_q;
    mpu_map_pkg::viol_t              flt_q;
    logic                            decide;
    logic                            bad;
    logic [mpu_bus_pkg::DAT_W-1:0]   rd_word;

    // lookup results are in once the request strobe has dropped
    assign decide = (state_q == ST_LOOK) && !req_q.valid;
    assign bad = viol_i.exv || viol_i.rdv || viol_i.wrv;

    // entry word for window reads, bits 25:20 read as zero
    assign rd_word = {rd_perm_i, 6'b0, rd_ppn_i};

    // window write lands at the decide edge and only when clean
    always_comb begin
        wr_o.en  = decide && req_q.win && req_q.we && !bad;
        wr_o.idx = req_q.adr[mpu_map_pkg::WIN_IDX_LSB +: mpu_map_pkg::IDX_W];
        wr_o.dat = out_q.dat;
    end

    // ==========================================================
    // request FSM
    // ==========================================================

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q     <= ST_IDLE;
            req_q.valid <= 1'b0;
            rsp_q.ack   <= 1'b0;
            rsp_q.err   <= 1'b0;
            out_q.cyc   <= 1'b0;
            out_q.stb   <= 1'b0;
            flt_q       <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (cyc_i && stb_i) begin
                        // capture once, the window test happens only here
                        req_q.valid <= 1'b1;
                        req_q.win   <= adr_i[mpu_bus_pkg::ADR_W-1 -: mpu_bus_pkg::WIN_HI_W]
                                       == mpu_bus_pkg::REG_BASE;
                        req_q.we    <= we_i;
                        req_q.ex    <= ex_i;
                        req_q.adr   <= adr_i;
                        out_q.we    <= we_i;
                        out_q.dat   <= dat_i;
                        state_q     <= ST_LOOK;
                    end
                end
                ST_LOOK: begin
                    if (req_q.valid) begin
                        // strobe lasts one cycle, tables register meanwhile
                        req_q.valid <= 1'b0;
                    end else if (bad) begin
                        rsp_q.ack <= 1'b1;
                        rsp_q.err <= 1'b1;
                        flt_q     <= viol_i;
                        state_q   <= ST_RESP;
                    end else if (req_q.win) begin
                        rsp_q.ack <= 1'b1;
                        rsp_q.dat <= rd_word;
                        state_q   <= ST_RESP;
                    end else begin
                        // physical address keeps the page offset
                        out_q.cyc <= 1'b1;
                        out_q.stb <= 1'b1;
                        out_q.adr <= {ppn_i, req_q.adr[mpu_map_pkg::PAGE_BITS-1:0]};
                        state_q   <= ST_OUT;
                    end
                end
                ST_OUT: begin
                    // hold the outbound cycle until memory answers
                    if (m_ack_i) begin
                        out_q.cyc <= 1'b0;
                        out_q.stb <= 1'b0;
                        rsp_q.ack <= 1'b1;
                        rsp_q.dat <= m_dat_i;
                        state_q   <= ST_RESP;
                    end
                end
                default: begin
                    // ack and flags last one cycle
                    rsp_q.ack <= 1'b0;
                    rsp_q.err <= 1'b0;
                    flt_q     <= '0;
                    state_q   <= ST_IDLE;
                end
            endcase
        end
    end

    assign req_o   = req_q;
    assign ack_o   = rsp_q.ack;
    assign err_o   = rsp_q.err;
    assign dat_o   = rsp_q.dat;
    assign m_cyc_o = out_q.cyc;
    assign m_stb_o = out_q.stb;
    assign m_we_o  = out_q.we;
    assign m_adr_o = out_q.adr;
    assign m_dat_o = out_q.dat;
    assign exv_o   = flt_q.exv;
    assign rdv_o   = flt_q.rdv;
    assign wrv_o   = flt_q.wrv;

endmodule

//--- compile.f
mpu_bus_pkg.sv
mpu_map_pkg.sv
page_map.sv
access_check.sv
bus_gate.sv
mpu_top.sv
mpu_tb.sv

//--- mpu_bus_pkg.sv
package mpu_bus_pkg;

    // ==========================================================
    // bus widths and register window
    // ==========================================================

    // one address word and one data word on both sides
    localparam int ADR_W = 32;
    localparam int DAT_W = 32;

    // high address bits that select the map register window
    localparam int WIN_HI_W = 24;
    localparam logic [WIN_HI_W-1:0] REG_BASE = 24'hFFDC00;

    // ==========================================================
    // bus structs
    // ==========================================================

    // request as captured from the slave port
    typedef struct packed {
        // one cycle strobe that starts both lookups
        logic             valid;
        // register window hit, decoded once at capture
        logic             win;
        logic             we;
        // instruction fetch
        logic             ex;
        logic [ADR_W-1:0] adr;
    } req_t;

    // response back to the master
    typedef struct packed {
        logic             ack;
        // error acknowledge on a violation
        logic             err;
        logic [DAT_W-1:0] dat;
    } rsp_t;

    // request on the outbound memory bus
    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [ADR_W-1:0] adr;
        logic [DAT_W-1:0] dat;
    } out_t;

endpackage

//--- mpu_map_pkg.sv
package mpu_map_pkg;

    // ==========================================================
    // page map geometry
    // ==========================================================

    // 4 KB pages
    localparam int PAGE_BITS = 12;
    // 64 map entries
    localparam int IDX_W = 6;
    localparam int N_ENT = 2 ** IDX_W;
    // 256 KB virtual window
    localparam int VA_BITS = PAGE_BITS + IDX_W;
    localparam int PPN_W = 20;
    // operating level width, level 0 is the most privileged
    localparam int OL_W = 2;

    // ==========================================================
    // entry word layout
    // ==========================================================

    // one entry word as the register window sees it
    localparam int ENT_W = 32;
    // permission bits sit at 31:26 in the order of perm_t
    localparam int PERM_LSB = 26;
    // word index inside the window comes from address bits 7:2
    localparam int WIN_IDX_LSB = 2;

    // rights of one page
    typedef struct packed {
        logic            valid;
        // least privileged level allowed
        logic [OL_W-1:0] pl;
        logic            x;
        logic            w;
        logic            r;
    } perm_t;

    // write into both tables from the register window
    typedef struct packed {
        logic             en;
        logic [IDX_W-1:0] idx;
        logic [ENT_W-1:0] dat;
    } map_wr_t;

    // violation kinds, at most one set per access
    typedef struct packed {
        logic exv;
        logic rdv;
        logic wrv;
    } viol_t;

endpackage

//--- mpu_tb.sv
`timescale 1ns/1ps

module mpu_tb;

    // ==========================================================
    // constants and trace storage
    // ==========================================================

    localparam int          CYC_PER_LINE = 40;
    // trace marker for an access that must stay inside the unit
    localparam logic [31:0] NO_OUT = 32'hFFFF_FFFF;
    // memory read data is its address with this pattern mixed in
    localparam logic [31:0] RD_MASK = 32'hA5A5_0000;

    // one access from the trace and its expected response
    typedef struct packed {
        logic        mapen;
        logic [1:0]  ol;
        logic        we;
        logic        ex;
        logic [31:0] adr;
        logic [31:0] wdat;
        logic        err;
        // {exv, rdv, wrv}
        logic [2:0]  fault;
        logic [31:0] oadr;
        logic [31:0] rdat;
    } step_t;

    step_t       steps[$];
    int          cycles;
    int          limit;

    logic        clk_i;
    logic        reset_i;
    logic        mapen_i;
    logic [1:0]  ol_i;
    logic        cyc_i;
    logic        stb_i;
    logic        we_i;
    logic        ex_i;
    logic [31:0] adr_i;
    logic [31:0] dat_i;
    logic        ack_o;
    logic        err_o;
    logic [31:0] dat_o;
    logic        m_cyc_o;
    logic        m_stb_o;
    logic        m_we_o;
    logic [31:0] m_adr_o;
    logic [31:0] m_dat_o;
    logic        m_ack_i;
    logic [31:0] m_dat_i;
    logic        exv_o;
    logic        rdv_o;
    logic        wrv_o;

    // last write seen by the memory model
    logic [31:0] wr_adr;
    logic [31:0] wr_dat;
    int          wr_cnt;
    int          delay;

    mpu_top mpu_top_i (.*);

    always #5 clk_i = ~clk_i;

    // ==========================================================
    // failure reporting
    // ==========================================================

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "%s", why);
    endtask

    // run limit grows with the trace length
    always @(posedge clk_i) begin
        cycles++;
        if (limit != 0 && cycles > limit) begin
            stop_run($sformatf("timeout after %0d cycles", cycles));
        end
    end

    // ==========================================================
    // memory responder
    // ==========================================================

    // random wait of 0 to 5 cycles, then a one cycle ack
    always begin
        @(negedge clk_i);
        if (m_cyc_o && m_stb_o) begin
            delay = $urandom % 6;
            repeat (delay) @(negedge clk_i);
            m_dat_i = m_adr_o ^ RD_MASK;
            if (m_we_o) begin
                wr_adr = m_adr_o;
                wr_dat = m_dat_o;
                wr_cnt++;
            end
            m_ack_i = 1'b1;
            @(negedge clk_i);
            m_ack_i = 1'b0;
        end
    end

    // ==========================================================
    // trace player
    // ==========================================================

    task automatic load_trace();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [10];
        step_t       st;
        fd = $fopen("mpu_trace.txt", "r");
        if (fd == 0) begin
            stop_run("cannot open mpu_trace.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // comment and blank lines carry no access
            if (line.len() > 8 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
                if (n != 10) begin
                    stop_run("malformed line in mpu_trace.txt");
                end
                st.mapen = f[0][0];
                st.ol    = f[1][1:0];
                st.we    = f[2][0];
                st.ex    = f[3][0];
                st.adr   = f[4];
                st.wdat  = f[5];
                st.err   = f[6][0];
                st.fault = f[7][2:0];
                st.oadr  = f[8];
                st.rdat  = f[9];
                steps.push_back(st);
            end
        end
        $fclose(fd);
    endtask

    task automatic run_step(input step_t st, input int num);
        int          waited;
        int          wr_before;
        logic        goes_out;
        logic        got_ack;
        logic        saw_cyc;
        logic [31:0] saw_adr;
        logic        got_err;
        logic [2:0]  got_flt;
        logic [31:0] got_dat;
        waited   = 0;
        goes_out = (st.oadr != NO_OUT);
        got_ack  = 1'b0;
        saw_cyc  = 1'b0;
        saw_adr  = '0;
        @(negedge clk_i);
        wr_before = wr_cnt;
        mapen_i = st.mapen;
        ol_i    = st.ol;
        we_i    = st.we;
        ex_i    = st.ex;
        adr_i   = st.adr;
        dat_i   = st.wdat;
        cyc_i   = 1'b1;
        stb_i   = 1'b1;
        // watch the outbound bus until the slave ack
        while (!got_ack) begin
            @(negedge clk_i);
            waited++;
            if (m_cyc_o || m_stb_o) begin
                // cyc and stb rise and fall together
                check_value("m_cyc_o", 32'(m_cyc_o), 32'd1);
                check_value("m_stb_o", 32'(m_stb_o), 32'd1);
                if (!saw_cyc) begin
                    saw_cyc = 1'b1;
                    saw_adr = m_adr_o;
                end
            end
            if (ack_o) begin
                got_ack = 1'b1;
                got_err = err_o;
                got_flt = {exv_o, rdv_o, wrv_o};
                got_dat = dat_o;
            end else if (waited > CYC_PER_LINE) begin
                stop_run($sformatf("trace line %0d got no ack", num));
            end
        end
        // master drops the strobe in the cycle after ack
        cyc_i = 1'b0;
        stb_i = 1'b0;
        if (saw_cyc && !goes_out) begin
            stop_run($sformatf("trace line %0d made an unexpected outbound cycle", num));
        end
        if (!saw_cyc && goes_out) begin
            stop_run($sformatf("trace line %0d made no outbound cycle", num));
        end
        check_value("err_o", 32'(got_err), 32'(st.err));
        check_value("{exv_o,rdv_o,wrv_o}", 32'(got_flt), 32'(st.fault));
        if (goes_out) begin
            check_value("m_adr_o", saw_adr, st.oadr);
        end
        if (!st.we && !st.err) begin
            check_value("dat_o", got_dat, st.rdat);
        end
        check_value("memory write count", 32'(wr_cnt), 32'(wr_before + (st.we && goes_out)));
        if (st.we && goes_out) begin
            check_value("memory write address", wr_adr, st.oadr);
            check_value("memory write data", wr_dat, st.wdat);
        end
    endtask

    initial begin
        void'($urandom(32'h75cc596a));
        clk_i   = 1'b0;
        reset_i = 1'b1;
        mapen_i = 1'b0;
        ol_i    = '0;
        cyc_i   = 1'b0;
        stb_i   = 1'b0;
        we_i    = 1'b0;
        ex_i    = 1'b0;
        adr_i   = '0;
        dat_i   = '0;
        m_ack_i = 1'b0;
        m_dat_i = '0;
        wr_adr  = '0;
        wr_dat  = '0;
        wr_cnt  = 0;
        cycles  = 0;
        limit   = 0;
        load_trace();
        if (steps.size() == 0) begin
            stop_run("mpu_trace.txt holds no accesses");
        end
        limit = CYC_PER_LINE * steps.size() + 10;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        foreach (steps[i]) begin
            run_step(steps[i], i);
        end
        $display("Test passed");
        $finish;
    end

endmodule

//--- mpu_top.sv
`timescale 1ns/1ps

module mpu_top (
    input  logic                                clk_i,
    input  logic                                reset_i,
    // mapping control from the master
    input  logic                                mapen_i,
    input  logic [mpu_map_pkg::OL_W-1:0]        ol_i,
    // slave port
    input  logic                                cyc_i,
    input  logic                                stb_i,
    input  logic                                we_i,
    input  logic                                ex_i,
    input  logic [mpu_bus_pkg::ADR_W-1:0]       adr_i,
    input  logic [mpu_bus_pkg::DAT_W-1:0]       dat_i,
    output logic                                ack_o,
    output logic                                err_o,
    output logic [mpu_bus_pkg::DAT_W-1:0]       dat_o,
    // outbound memory bus
    output logic                                m_cyc_o,
    output logic                                m_stb_o,
    output logic                                m_we_o,
    output logic [mpu_bus_pkg::ADR_W-1:0]       m_adr_o,
    output logic [mpu_bus_pkg::DAT_W-1:0]       m_dat_o,
    input  logic                                m_ack_i,
    input  logic [mpu_bus_pkg::DAT_W-1:0]       m_dat_i,
    // fault flags
    output logic                                exv_o,
    output logic                                rdv_o,
    output logic                                wrv_o
);

    mpu_bus_pkg::req_t             req_q;
    mpu_map_pkg::map_wr_t          map_wr;
    logic [mpu_map_pkg::PPN_W-1:0] ppn_q;
    logic [mpu_map_pkg::PPN_W-1:0] rd_ppn;
    mpu_map_pkg::viol_t            viol_q;
    mpu_map_pkg::perm_t            rd_perm;

    // ==========================================================
    // gate in front, both tables look up in parallel
    // ==========================================================

    bus_gate gate_i (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .cyc_i     (cyc_i),
        .stb_i     (stb_i),
        .we_i      (we_i),
        .ex_i      (ex_i),
        .adr_i     (adr_i),
        .dat_i     (dat_i),
        .ack_o     (ack_o),
        .err_o     (err_o),
        .dat_o     (dat_o),
        .m_cyc_o   (m_cyc_o),
        .m_stb_o   (m_stb_o),
        .m_we_o    (m_we_o),
        .m_adr_o   (m_adr_o),
        .m_dat_o   (m_dat_o),
        .m_ack_i   (m_ack_i),
        .m_dat_i   (m_dat_i),
        .req_o     (req_q),
        .wr_o      (map_wr),
        .ppn_i     (ppn_q),
        .viol_i    (viol_q),
        .rd_ppn_i  (rd_ppn),
        .rd_perm_i (rd_perm),
        .exv_o     (exv_o),
        .rdv_o     (rdv_o),
        .wrv_o     (wrv_o)
    );

    // translation half of the map
    page_map map_i (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .req_i    (req_q),
        .wr_i     (map_wr),
        .mapen_i  (mapen_i),
        .ppn_o    (ppn_q),
        .rd_ppn_o (rd_ppn)
    );

    // permission half of the map
    access_check check_i (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .req_i     (req_q),
        .wr_i      (map_wr),
        .mapen_i   (mapen_i),
        .ol_i      (ol_i),
        .viol_o    (viol_q),
        .rd_perm_o (rd_perm)
    );

endmodule

//--- mpu_trace.txt
# mapen ol we ex adr wdat err fault oadr rdat (hex), fault 4 exv 2 rdv 1 wrv 0 none
# oadr ffffffff means no outbound cycle, rdat is checked on reads without err
1 0 0 0 00001000 00000000 1 2 ffffffff 00000000
0 0 0 0 12345678 00000000 0 0 12345678 b7915678
0 0 1 0 00abc004 deadbeef 0 0 00abc004 00000000
0 0 0 0 80000010 00000000 0 0 80000010 25a50010
0 3 0 1 00002000 00000000 0 0 00002000 a5a52000
0 2 1 0 40000100 11223344 0 0 40000100 00000000
0 0 1 0 ffdc0000 fff00040 0 0 ffffffff 00000000
0 0 1 0 ffdc0004 ac012345 0 0 ffffffff 00000000
1 0 1 0 ffdc0008 90000abc 0 0 ffffffff 00000000
1 0 1 0 ffdc000c 7c000777 0 0 ffffffff 00000000
1 0 1 0 ffdc0010 f4080001 0 0 ffffffff 00000000
0 0 1 0 ffdc0014 e4000005 0 0 ffffffff 00000000
0 0 0 0 ffdc0000 00000000 0 0 ffffffff fc000040
1 3 0 0 ffdc0004 00000000 0 0 ffffffff ac012345
1 0 0 0 ffdc0010 00000000 0 0 ffffffff f4080001
1 0 0 0 00000abc 00000000 0 0 00040abc a5a10abc
1 0 1 0 00000ffc cafef00d 0 0 00040ffc 00000000
1 0 0 1 00000100 00000000 0 0 00040100 a5a10100
1 1 0 0 00001234 00000000 0 0 12345234 b7915234
1 1 1 0 00001008 0badcafe 0 0 12345008 00000000
1 0 0 1 00002010 00000000 0 0 00abc010 a50ec010
1 3 0 0 00004800 00000000 0 0 80001800 25a51800
1 3 0 1 00004004 00000000 0 0 80001004 25a51004
1 2 0 0 00005ff0 00000000 0 0 00005ff0 a5a55ff0
1 0 0 0 00003000 00000000 1 2 ffffffff 00000000
1 0 0 1 00003ffc 00000000 1 4 ffffffff 00000000
1 0 0 0 0000a000 00000000 1 2 ffffffff 00000000
1 2 0 0 00001000 00000000 1 2 ffffffff 00000000
1 1 0 1 00002000 00000000 1 4 ffffffff 00000000
1 2 1 0 00001010 55555555 1 1 ffffffff 00000000
1 0 0 0 00002004 00000000 1 2 ffffffff 00000000
1 0 1 0 00004000 66666666 1 1 ffffffff 00000000
1 0 0 1 00001000 00000000 1 4 ffffffff 00000000
1 3 1 0 00005000 77777777 1 1 ffffffff 00000000
1 0 0 0 00040000 00000000 1 2 ffffffff 00000000
1 0 1 0 00041000 88888888 1 1 ffffffff 00000000
1 0 0 1 10000000 00000000 1 4 ffffffff 00000000
1 1 1 0 ffdc0004 00000000 1 1 ffffffff 00000000
1 0 0 0 ffdc0004 00000000 0 0 ffffffff ac012345
0 2 1 0 ffdc0000 12345678 1 1 ffffffff 00000000
0 0 0 0 ffdc0000 00000000 0 0 ffffffff fc000040
1 0 0 0 00000010 00000000 0 0 00040010 a5a10010

//--- page_map.sv
`timescale 1ns/1ps

module page_map (
    input  logic                                clk_i,
    input  logic                                reset_i,
    // captured request, valid for one cycle
    input  mpu_bus_pkg::req_t                   req_i,
    // register window write
    input  mpu_map_pkg::map_wr_t                wr_i,
    input  logic                                mapen_i,
    // physical page for the access
    output logic [mpu_map_pkg::PPN_W-1:0]       ppn_o,
    // page number half of a window readback
    output logic [mpu_map_pkg::PPN_W-1:0]       rd_ppn_o
);

    // physical page number of each virtual page
    logic [mpu_map_pkg::PPN_W-1:0] ppn_mem [mpu_map_pkg::N_ENT];

    // virtual page index from address bits 17:12
    logic [mpu_map_pkg::IDX_W-1:0] va_idx;
    // entry index of a window access from address bits 7:2
    logic [mpu_map_pkg::IDX_W-1:0] rd_idx;
    // upper address bits used when nothing is translated
    logic [mpu_map_pkg::PPN_W-1:0] flat_ppn;
    logic                          translate;

    assign va_idx = req_i.adr[mpu_map_pkg::PAGE_BITS +: mpu_map_pkg::IDX_W];
    assign rd_idx = req_i.adr[mpu_map_pkg::WIN_IDX_LSB +: mpu_map_pkg::IDX_W];
    assign flat_ppn = req_i.adr[mpu_bus_pkg::ADR_W-1 -: mpu_map_pkg::PPN_W];

    // window accesses always see the flat address
    assign translate = mapen_i && !req_i.win;

    // ==========================================================
    // table write port
    // ==========================================================

    // the low 20 bits of the entry word hold the page number
    always_ff @(posedge clk_i) begin
        if (wr_i.en) begin
            ppn_mem[wr_i.idx] <= wr_i.dat[mpu_map_pkg::PPN_W-1:0];
        end
    end

    // ==========================================================
    // registered lookup
    // ==========================================================

    // results hold until the next request strobe
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ppn_o    <= '0;
            rd_ppn_o <= '0;
        end else if (req_i.valid) begin
            if (translate) begin
                ppn_o <= ppn_mem[va_idx];
            end else begin
                ppn_o <= flat_ppn;
            end
            // readback only for window reads
            if (req_i.win && !req_i.we) begin
                rd_ppn_o <= ppn_mem[rd_idx];
            end
        end
    end

endmodule
